/* src/limb_macros.svh */
`ifndef LIMB_MACROS_SVH
`define LIMB_MACROS_SVH

// float word width
`define FP_W 32

// upper joint limit, pi rad
`define LIMB_POS_MAX 32'h40490FDB

// 1/I with I = 0.0372, about 26.8817
`define LIMB_IINV 32'h41D70DC3

// euler step, 0.001 s
`define LIMB_DT 32'h3A83126F

`endif

/* src/fp_pkg.sv */
package fp_pkg;

    // ieee 754 single precision, field view
    typedef struct packed {
        logic       sign;      // 1 = negative
        logic [7:0] exponent;  // biased by 127
        logic [22:0] mantissa; // hidden one not stored
    } fp_fields_t;

    // one float word, read raw or split into fields
    // raw view is for compares and constants
    // field view is for the arithmetic units
    typedef union packed {
        logic [31:0] raw;
        fp_fields_t  fields;
    } fp_word_t;

    // exponent of zero means zero or subnormal
    // both are treated as zero everywhere

endpackage

/* src/limb_pkg.sv */
package limb_pkg;

    // torques applied to one joint, sampled every clk
    typedef struct packed {
        fp_pkg::fp_word_t trq_inc; // non-negative, pushes the angle up
        fp_pkg::fp_word_t trq_dec; // non-negative, pushes the angle down
        fp_pkg::fp_word_t trq_ext; // signed disturbance
    } joint_in_t;

    // values loaded while reset is high
    typedef struct packed {
        fp_pkg::fp_word_t pos_default; // rad
        fp_pkg::fp_word_t vel_default; // rad/s
    } joint_init_t;

    // registered joint state
    typedef struct packed {
        fp_pkg::fp_word_t trq; // net torque
        fp_pkg::fp_word_t acc; // rad/s^2
        fp_pkg::fp_word_t vel; // rad/s
        fp_pkg::fp_word_t pos; // rad, held in 0..pi
    } joint_state_t;

endpackage

/* src/fp_addsub.sv */
`timescale 1ns/1ps

module fp_addsub (
    input  fp_pkg::fp_word_t a,
    input  fp_pkg::fp_word_t b,
    input  logic             sub, // 1 = a - b
    output fp_pkg::fp_word_t sum
);

    fp_pkg::fp_word_t b_eff;       // b with sign flipped for subtract
    logic [30:0]      a_mag, b_mag; // magnitudes, subnormals flushed
    logic             swap;
    logic [30:0]      big_mag, small_mag;
    logic             big_sign, small_sign;
    logic [7:0]       diff;        // exponent difference
    logic [26:0]      big_full, small_full, small_sh, small_al;
    logic             sticky;
    logic [27:0]      sum_raw;     // carry + hidden + 23 + g r s
    logic             carry;
    logic [4:0]       lz;
    logic [26:0]      norm;
    logic signed [9:0] exp_n, exp_r;
    logic             round_up;
    logic [24:0]      mant_r;
    logic             res_zero;

    // leading zero count, bit 26 is the hidden one position
    function automatic logic [4:0] lzc27(input logic [26:0] v);
        logic [4:0] n;
        n = 5'd27;
        for (int i = 0; i < 27; i++) begin
            if (v[i]) n = 5'(26 - i); // highest set bit wins
        end
        return n;
    endfunction

    assign b_eff.raw = {b.fields.sign ^ sub, b.raw[30:0]};

    assign a_mag = (a.fields.exponent == 8'd0) ? 31'd0 : a.raw[30:0];
    assign b_mag = (b_eff.fields.exponent == 8'd0) ? 31'd0 : b_eff.raw[30:0];

    // larger magnitude goes first, so the mantissa difference stays positive
    assign swap       = (b_mag > a_mag);
    assign big_mag    = swap ? b_mag : a_mag;
    assign small_mag  = swap ? a_mag : b_mag;
    assign big_sign   = swap ? b_eff.fields.sign : a.fields.sign;
    assign small_sign = swap ? a.fields.sign : b_eff.fields.sign;

    assign diff = big_mag[30:23] - small_mag[30:23];

    // hidden bit only when exponent nonzero, three extra bits below
    assign big_full   = {|big_mag[30:23], big_mag[22:0], 3'b000};
    assign small_full = {|small_mag[30:23], small_mag[22:0], 3'b000};

    // align, anything shifted out lands in sticky
    assign small_sh = small_full >> diff;
    assign sticky   = ((small_sh << diff) != small_full);
    assign small_al = {small_sh[26:1], small_sh[0] | sticky};

    assign sum_raw = (big_sign ^ small_sign) ? ({1'b0, big_full} - {1'b0, small_al})
                                             : ({1'b0, big_full} + {1'b0, small_al});

    assign carry = sum_raw[27];
    assign lz    = lzc27(sum_raw[26:0]);

    // renormalize: right by one on carry, else left after cancellation
    assign norm  = carry ? {sum_raw[27:2], sum_raw[1] | sum_raw[0]} : (sum_raw[26:0] << lz);
    assign exp_n = carry ? ({2'b00, big_mag[30:23]} + 10'sd1)
                         : ({2'b00, big_mag[30:23]} - {5'd0, lz});

    // nearest even on guard, round|sticky, lsb
    assign round_up = norm[2] & (norm[1] | norm[0] | norm[3]);
    assign mant_r   = {1'b0, norm[26:3]} + 25'(round_up);
    assign exp_r    = exp_n + {9'd0, mant_r[24]};

    // exact zero or underflow gives +0
    assign res_zero = (sum_raw == 28'd0) || (exp_r <= 0);

    // on rounding carry mant_r is 1.0, low bits already zero
    assign sum.raw = res_zero ? 32'd0 : {big_sign, exp_r[7:0], mant_r[22:0]};

endmodule

/* src/fp_mult.sv */
`timescale 1ns/1ps

module fp_mult (
    input  fp_pkg::fp_word_t a,
    input  fp_pkg::fp_word_t b,
    output fp_pkg::fp_word_t prod
);

    localparam logic [9:0] exp_bias = 10'd127;

    logic              a_zero, b_zero;
    logic [47:0]       p;        // 24 x 24 mantissa product
    logic              hi;       // product in [2,4)
    logic [22:0]       mant_t;   // truncated fraction
    logic              guard, sticky;
    logic              round_up;
    logic [23:0]       mant_r;
    logic signed [9:0] exp_s;
    logic              res_zero;

    // zero and subnormal operands both count as zero
    assign a_zero = (a.fields.exponent == 8'd0);
    assign b_zero = (b.fields.exponent == 8'd0);

    assign p  = {1'b1, a.fields.mantissa} * {1'b1, b.fields.mantissa};
    assign hi = p[47];

    // at most one bit of normalization
    assign mant_t = hi ? p[46:24] : p[45:23];
    assign guard  = hi ? p[23] : p[22];
    assign sticky = hi ? |p[22:0] : |p[21:0];

    assign round_up = guard & (sticky | mant_t[0]); // ties to even
    assign mant_r   = {1'b0, mant_t} + 24'(round_up);

    // sum of biased exponents minus one bias, plus normalize and round carries
    assign exp_s = {2'b00, a.fields.exponent} + {2'b00, b.fields.exponent} - exp_bias
                 + {9'd0, hi} + {9'd0, mant_r[23]};

    assign res_zero = a_zero || b_zero || (exp_s <= 0); // underflow flushes

    // rounding carry leaves fraction bits at zero
    assign prod.raw = res_zero ? 32'd0
                               : {a.fields.sign ^ b.fields.sign, exp_s[7:0], mant_r[22:0]};

endmodule

/* src/integrator.sv */
`timescale 1ns/1ps
`include "limb_macros.svh"

module integrator (
    input  fp_pkg::fp_word_t x,     // rate
    input  fp_pkg::fp_word_t int_x, // current value
    output fp_pkg::fp_word_t out    // value one step later
);

    localparam logic [`FP_W-1:0] dt_word = `LIMB_DT;

    fp_pkg::fp_word_t dt;
    fp_pkg::fp_word_t step; // x * dt

    assign dt.raw = dt_word;

    fp_mult u_mult (
        .a    (x),
        .b    (dt),
        .prod (step)
    );

    // forward euler: int_x + x*dt
    fp_addsub u_add (
        .a   (int_x),
        .b   (step),
        .sub (1'b0),
        .sum (out)
    );

endmodule

/* src/limb.sv */
`timescale 1ns/1ps
`include "limb_macros.svh"

module limb (
    input  logic                   clk,
    input  logic                   reset,
    input  limb_pkg::joint_in_t    joint_in,
    input  limb_pkg::joint_init_t  init,  // loaded during reset
    output limb_pkg::joint_state_t state
);

    localparam logic [`FP_W-1:0] pos_max_word = `LIMB_POS_MAX;
    localparam logic [`FP_W-1:0] iinv_word    = `LIMB_IINV;

    fp_pkg::fp_word_t pos_max, iinv;
    fp_pkg::fp_word_t trq_diff;  // inc - dec
    fp_pkg::fp_word_t trq_net;   // plus external
    fp_pkg::fp_word_t acc_next;
    fp_pkg::fp_word_t vel_next;
    fp_pkg::fp_word_t pos_raw;   // before clamp
    fp_pkg::fp_word_t pos_next;
    logic             below_min, at_max;

    assign pos_max.raw = pos_max_word;
    assign iinv.raw    = iinv_word;

    // muscle pair works against each other
    fp_addsub u_trq_diff (
        .a   (joint_in.trq_inc),
        .b   (joint_in.trq_dec),
        .sub (1'b1),
        .sum (trq_diff)
    );

    fp_addsub u_trq_sum (
        .a   (trq_diff),
        .b   (joint_in.trq_ext),
        .sub (1'b0),
        .sum (trq_net)
    );

    // acc = trq / I
    fp_mult u_acc (
        .a    (trq_net),
        .b    (iinv),
        .prod (acc_next)
    );

    // registered acc feeds vel, registered vel feeds pos
    integrator u_int_acc (.x(state.acc), .int_x(state.vel), .out(vel_next));
    integrator u_int_vel (.x(state.vel), .int_x(state.pos), .out(pos_raw));

    // adder gives +0 on zero, so the sign bit alone marks negative
    assign below_min = pos_raw.fields.sign;
    // positive floats order like their magnitude bits
    assign at_max    = !pos_raw.fields.sign && (pos_raw.raw[30:0] >= pos_max.raw[30:0]);

    assign pos_next = below_min ? fp_pkg::fp_word_t'(32'd0) : (at_max ? pos_max : pos_raw);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state.trq <= '0;
            state.acc <= '0;
            state.vel <= init.vel_default;
            state.pos <= init.pos_default;
        end else begin
            state.trq <= trq_net;
            state.acc <= at_max ? fp_pkg::fp_word_t'(32'd0) : acc_next; // stop at the limit
            state.vel <= at_max ? fp_pkg::fp_word_t'(32'd0) : vel_next;
            state.pos <= pos_next;
        end
    end

endmodule

/* src/arm_top.sv */
`timescale 1ns/1ps

module arm_top (
    input  logic                   clk,
    input  logic                   reset,
    input  limb_pkg::joint_in_t    shoulder_in,
    input  limb_pkg::joint_in_t    elbow_in,
    input  limb_pkg::joint_init_t  shoulder_init,
    input  limb_pkg::joint_init_t  elbow_init,
    output limb_pkg::joint_state_t shoulder_state,
    output limb_pkg::joint_state_t elbow_state
);

    // joints are not coupled, each runs its own dynamics
    limb u_shoulder (
        .clk      (clk),
        .reset    (reset),
        .joint_in (shoulder_in),
        .init     (shoulder_init),
        .state    (shoulder_state)
    );

    limb u_elbow (
        .clk      (clk),
        .reset    (reset),
        .joint_in (elbow_in),
        .init     (elbow_init),
        .state    (elbow_state)
    );

endmodule

/* verif/arm_assert.sv */
`timescale 1ns/1ps
`include "limb_macros.svh"

module arm_assert (
    input logic                   clk,
    input logic                   reset,
    input limb_pkg::joint_state_t state,
    input fp_pkg::fp_word_t       pos_raw // unclamped next position inside limb
);

    localparam logic [`FP_W-1:0] pos_max_word = `LIMB_POS_MAX;

    logic raw_at_max;

    // positive floats order like their bits
    assign raw_at_max = !pos_raw.fields.sign && (pos_raw.raw[30:0] >= pos_max_word[30:0]);

    pos_not_negative: assert property (@(posedge clk) disable iff (reset)
        !state.pos.fields.sign)
        else $error("joint position is negative");

    pos_within_limit: assert property (@(posedge clk) disable iff (reset)
        state.pos.raw[30:0] <= pos_max_word[30:0])
        else $error("joint position is above the upper limit");

    // reaching the limit stops the joint on the next state
    stop_at_limit: assert property (@(posedge clk) disable iff (reset)
        raw_at_max |=> (state.pos.raw == pos_max_word) && (state.acc.raw == 32'd0)
                       && (state.vel.raw == 32'd0))
        else $error("joint at the limit still has nonzero acc or vel");

endmodule

bind limb arm_assert u_assert (
    .clk     (clk),
    .reset   (reset),
    .state   (state),
    .pos_raw (pos_raw)
);

/* verif/arm_tb.sv */
`timescale 1ns/1ps
`include "limb_macros.svh"

module arm_tb;

    // cycles per test, each with its 2 reset cycles
    localparam int total_cycles = 5 + 10 + 42 + 17 + 32 + 22;
    localparam int timeout_ns   = (total_cycles + 20) * 100; // 20 cycles slack

    logic                   clk = 1'b0;
    logic                   reset;
    limb_pkg::joint_in_t    shoulder_in, elbow_in;
    limb_pkg::joint_init_t  shoulder_init, elbow_init;
    limb_pkg::joint_state_t shoulder_state, elbow_state;

    logic [31:0] seed = 32'h2ae83761;
    string       test_name;
    int          errors = 0;
    int          flow_errors = 0; // counted by the stimulus process
    int          checks = 0;
    int          hi_hits = 0;     // model cycles clamped at pi
    int          lo_hits = 0;     // model cycles clamped at zero
    real         ref_trq[2], ref_acc[2], ref_vel[2], ref_pos[2]; // 0 shoulder, 1 elbow
    logic        clamp_hi[2], clamp_lo[2];

    arm_top uut (
        .clk            (clk),
        .reset          (reset),
        .shoulder_in    (shoulder_in),
        .elbow_in       (elbow_in),
        .shoulder_init  (shoulder_init),
        .elbow_init     (elbow_init),
        .shoulder_state (shoulder_state),
        .elbow_state    (elbow_state)
    );

    always #50 clk = ~clk; // 100 ns period

    // single float word to real, zero and subnormal read as 0
    function automatic real to_real(input logic [31:0] w);
        logic [10:0] e;
        if (w[30:23] == 8'd0) return 0.0;
        e = {3'b000, w[30:23]} + 11'd896; // bias 127 -> 1023
        return $bitstoreal({w[31], e, w[22:0], 29'd0});
    endfunction

    function automatic logic [31:0] to_word(input real r);
        logic [63:0] d;
        logic [10:0] e;
        d = $realtobits(r);
        e = d[62:52] - 11'd896;
        if (r == 0.0) return 32'd0;
        return {d[63], e[7:0], d[51:29]}; // low mantissa bits dropped
    endfunction

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic real uniform(input real lo, input real hi);
        seed = lcg_next(seed);
        return lo + (hi - lo) * real'(seed[31:8]) / 16777216.0; // top 24 bits
    endfunction

    function automatic int coin();
        seed = lcg_next(seed);
        return seed[31] ? 1 : -1;
    endfunction

    function automatic limb_pkg::joint_in_t torque_set(input real inc, input real dec,
                                                       input real ext);
        limb_pkg::joint_in_t t;
        t.trq_inc.raw = to_word(inc);
        t.trq_dec.raw = to_word(dec);
        t.trq_ext.raw = to_word(ext);
        return t;
    endfunction

    // net torque at least 0.15 in size, sign picked by dir
    function automatic limb_pkg::joint_in_t random_torque(input int dir);
        real big, small_t, ext;
        big     = uniform(0.5, 1.0);
        small_t = uniform(0.0, 0.25);
        ext     = uniform(-0.1, 0.1);
        if (dir > 0) return torque_set(big, small_t, ext);
        return torque_set(small_t, big, ext);
    endfunction

    function automatic limb_pkg::joint_init_t init_set(input real pos, input real vel);
        limb_pkg::joint_init_t v;
        v.pos_default.raw = to_word(pos);
        v.vel_default.raw = to_word(vel);
        return v;
    endfunction

    // one clock of joint j in real arithmetic
    function automatic void step_ref(input int j, input limb_pkg::joint_in_t jin,
                                     input limb_pkg::joint_init_t jinit, input logic rst);
        real lim, dt, trq_n, acc_n, vel_n, pos_n;
        lim = to_real(`LIMB_POS_MAX);
        dt  = to_real(`LIMB_DT);
        clamp_hi[j] = 1'b0;
        clamp_lo[j] = 1'b0;
        if (rst) begin // defaults, torque path cleared
            ref_trq[j] = 0.0;
            ref_acc[j] = 0.0;
            ref_vel[j] = to_real(jinit.vel_default.raw);
            ref_pos[j] = to_real(jinit.pos_default.raw);
            return;
        end
        trq_n = to_real(jin.trq_inc.raw) - to_real(jin.trq_dec.raw) + to_real(jin.trq_ext.raw);
        acc_n = trq_n / 0.0372; // inertia 0.0372
        vel_n = ref_vel[j] + ref_acc[j] * dt; // old acc feeds vel
        pos_n = ref_pos[j] + ref_vel[j] * dt; // old vel feeds pos
        if (pos_n < 0.0) begin
            pos_n       = 0.0;
            clamp_lo[j] = 1'b1;
        end else if (pos_n >= lim) begin
            pos_n       = lim;
            acc_n       = 0.0; // joint stopped at the limit
            vel_n       = 0.0;
            clamp_hi[j] = 1'b1;
        end
        ref_trq[j] = trq_n;
        ref_acc[j] = acc_n;
        ref_vel[j] = vel_n;
        ref_pos[j] = pos_n;
    endfunction

    task automatic check_val(input string joint, input string field, input real exp_v,
                             input logic [31:0] act_w);
        real act, tol;
        act = to_real(act_w);
        tol = 1.0e-4 * ((exp_v < 0.0) ? -exp_v : exp_v) + 1.0e-6; // relative plus absolute
        checks++;
        if ((act > exp_v + tol) || (act < exp_v - tol)) begin
            errors++;
            $display("FAILED %s %s.%s: expected %g, actual %g", test_name, joint, field,
                     exp_v, act);
        end
    endtask

    task automatic check_word(input string joint, input string field, input logic [31:0] exp_w,
                              input logic [31:0] act_w);
        checks++;
        if (act_w != exp_w) begin
            errors++;
            $display("FAILED %s %s.%s: expected %h, actual %h", test_name, joint, field,
                     exp_w, act_w);
        end
    endtask

    task automatic compare_joint(input int j, input string joint,
                                 input limb_pkg::joint_state_t st);
        check_val(joint, "trq", ref_trq[j], st.trq.raw);
        check_val(joint, "acc", ref_acc[j], st.acc.raw);
        check_val(joint, "vel", ref_vel[j], st.vel.raw);
        check_val(joint, "pos", ref_pos[j], st.pos.raw);
        if (clamp_hi[j]) begin // clamped values must be exact
            hi_hits++;
            check_word(joint, "pos_limit", `LIMB_POS_MAX, st.pos.raw);
            check_word(joint, "acc_limit", 32'd0, st.acc.raw);
            check_word(joint, "vel_limit", 32'd0, st.vel.raw);
        end
        if (clamp_lo[j]) begin
            lo_hits++;
            check_word(joint, "pos_zero", 32'd0, st.pos.raw);
        end
    endtask

    // model and compare, once the edge has settled
    always @(posedge clk) begin
        #10;
        step_ref(0, shoulder_in, shoulder_init, reset);
        step_ref(1, elbow_in, elbow_init, reset);
        compare_joint(0, "shoulder", shoulder_state);
        compare_joint(1, "elbow", elbow_state);
    end

    // returns right after a falling edge with reset low
    task automatic apply_reset(input real s_pos, input real s_vel, input real e_pos,
                               input real e_vel);
        shoulder_init = init_set(s_pos, s_vel);
        elbow_init    = init_set(e_pos, e_vel);
        reset = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    endtask

    initial begin
        int hi_start, lo_start;
        shoulder_in = '0;
        elbow_in    = '0;
        test_name   = "reset";
        apply_reset(1.0, 0.25, 2.0, -0.5); // defaults differ per joint
        repeat (3) @(negedge clk);

        test_name = "const_torque";
        apply_reset(uniform(0.8, 1.6), uniform(-0.2, 0.2), uniform(1.6, 2.4), uniform(-0.2, 0.2));
        shoulder_in = random_torque(coin());
        elbow_in    = random_torque(coin());
        repeat (8) @(negedge clk);

        test_name = "integration";
        apply_reset(uniform(1.2, 1.8), uniform(-0.3, 0.3), uniform(1.2, 1.8), uniform(-0.3, 0.3));
        for (int i = 0; i < 40; i++) begin // fresh torques every cycle
            shoulder_in = random_torque(coin());
            elbow_in    = random_torque(coin());
            @(negedge clk);
        end

        test_name = "upper_clamp";
        hi_start  = hi_hits;
        apply_reset(3.12, 2.0, 3.11, 2.5); // both just below pi
        shoulder_in = torque_set(uniform(2.5, 3.0), uniform(0.0, 0.2), uniform(0.0, 0.2));
        elbow_in    = torque_set(uniform(2.0, 2.5), uniform(0.0, 0.2), uniform(0.0, 0.2));
        repeat (15) @(negedge clk);
        if (hi_hits == hi_start) begin
            flow_errors++;
            $display("upper clamp test never drove a joint to the limit");
        end

        test_name = "lower_clamp";
        lo_start  = lo_hits;
        apply_reset(0.02, -1.0, 0.03, -0.8);
        shoulder_in = torque_set(uniform(0.3, 0.5), uniform(2.5, 3.0), uniform(-0.2, 0.0));
        elbow_in    = torque_set(uniform(0.2, 0.4), uniform(2.0, 2.5), uniform(-0.2, 0.0));
        repeat (30) @(negedge clk); // long enough to hold at zero
        if (lo_hits == lo_start) begin
            flow_errors++;
            $display("lower clamp test never drove a joint to zero");
        end

        test_name = "independence";
        apply_reset(1.0, 0.5, 2.0, -0.5);
        for (int i = 0; i < 20; i++) begin
            shoulder_in = random_torque(1);  // pushes up
            elbow_in    = random_torque(-1); // pushes down
            @(negedge clk);
        end

        $display("checks: %0d, errors: %0d", checks, errors + flow_errors);
        if (errors + flow_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        #(timeout_ns);
        $display("timeout: tests still running after %0d ns", timeout_ns);
        $display("Done: errors found");
        $finish;
    end

endmodule

/* flist.f */
+incdir+src
src/fp_pkg.sv
src/limb_pkg.sv
src/fp_addsub.sv
src/fp_mult.sv
src/integrator.sv
src/limb.sv
src/arm_top.sv
verif/arm_assert.sv
verif/arm_tb.sv

/* run.sh */
#!/bin/sh
# build and run the arm testbench with verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --assert --top-module arm_tb -f flist.f -o arm_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/arm_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Done: no errors$" sim.log; then
    exit 0
fi
exit 1
